// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= irq_gen_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/irq_gen_params.svh ====
`ifndef IRQ_GEN_PARAMS_SVH
`define IRQ_GEN_PARAMS_SVH

////////////////////
// Word buffer
////////////////////

// Number of interrupt words held between producer and consumer
`define IRQ_FIFO_DEPTH 4

////////////////////
// Random source
////////////////////

// LFSR state after reset, never zero
`define IRQ_LFSR_SEED 32'h1
// Galois tap mask, applied when the bit shifted out is set
`define IRQ_LFSR_TAPS 32'h80200003

// Bit positions of the physical lines inside a 32-bit word
`define IRQ_SW_BIT    3
`define IRQ_TIMER_BIT 7
`define IRQ_EXT_BIT   11
`define IRQ_FAST_LSB  16

`endif

// ==== hdl/irq_gen_pkg.sv ====
package irq_gen_pkg;

  ////////////////////
  // Interrupt words
  ////////////////////

  // Raw 32-bit interrupt word as built by the producer
  typedef logic [31:0] irq_word_t;

  // Source of interrupt words
  typedef enum logic [1:0] {
    // All pending requests cleared
    STANDARD         = 2'd0,
    // LFSR word after an LFSR delay
    RANDOM           = 2'd1,
    // Word raised on a program counter match
    PC_TRIG          = 2'd2,
    // Strobed word taken as is
    SOFTWARE_DEFINED = 2'd3
  } irq_mode_e;

  ////////////////////
  // Line driver
  ////////////////////

  // Consumer FSM states
  typedef enum logic [1:0] {
    // Waiting for a word in the FIFO
    IDLE,
    // Lines held until the core acknowledges
    ASSERT,
    // Lines cleared, id write enable high
    ACK
  } drv_state_e;

  // Physical interrupt lines, software line in the MSB
  typedef struct packed {
    logic        irq_software;
    logic        irq_timer;
    logic        irq_external;
    logic [15:0] irq_fast;
  } irq_lines_t;

endpackage

// ==== hdl/irq_gen_top.sv ====
`timescale 1ns/1ps

module irq_gen_top import irq_gen_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Source select
  input  logic [1:0]  irq_mode_i,
  // Random mode bounds
  input  logic [15:0] irq_min_cycles_i,
  input  logic [15:0] irq_max_cycles_i,
  input  logic [4:0]  irq_min_id_i,
  input  logic [4:0]  irq_max_id_i,
  // PC trigger
  input  logic [31:0] irq_pc_i,
  input  logic [31:0] irq_pc_trig_i,
  // Software word, also the PC-triggered payload
  input  logic [31:0] sw_lines_i,
  input  logic        sw_valid_i,
  // Core side
  input  logic        irq_ack_i,
  output irq_lines_t  irq_lines_o,
  output logic [4:0]  irq_act_id_o,
  output logic        irq_id_we_o,
  output logic        irq_overflow_o
);

  // Producer to FIFO to consumer
  irq_word_if word_if ();

  irq_word_source u_source (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_mode_i   (irq_mode_e'(irq_mode_i)),
    .min_cycles_i (irq_min_cycles_i),
    .max_cycles_i (irq_max_cycles_i),
    .min_id_i     (irq_min_id_i),
    .max_id_i     (irq_max_id_i),
    .pc_i         (irq_pc_i),
    .pc_trig_i    (irq_pc_trig_i),
    .sw_lines_i   (sw_lines_i),
    .sw_valid_i   (sw_valid_i),
    .word_o       (word_if.producer)
  );

  irq_word_fifo u_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .buf_io     (word_if.buffer),
    .overflow_o (irq_overflow_o)
  );

  irq_line_driver u_driver (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_i       (word_if.consumer),
    .irq_ack_i    (irq_ack_i),
    .irq_lines_o  (irq_lines_o),
    .irq_act_id_o (irq_act_id_o),
    .irq_id_we_o  (irq_id_we_o)
  );

endmodule

// ==== hdl/irq_line_driver.sv ====
`timescale 1ns/1ps
`include "irq_gen_params.svh"

module irq_line_driver import irq_gen_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  irq_word_if.consumer  word_i,
  input  logic          irq_ack_i,
  output irq_lines_t    irq_lines_o,
  output logic [4:0]    irq_act_id_o,
  output logic          irq_id_we_o
);

  drv_state_e state_q;
  irq_lines_t lines_q;
  irq_lines_t lines_map;
  logic [4:0] id_q;
  logic [4:0] id_cur;
  logic       we_q;

  // Highest-numbered set line wins, fast lines on top
  function automatic logic [4:0] line_id(irq_lines_t l);
    logic [4:0] id;
    id = '0;
    if (l.irq_software) id = 5'(`IRQ_SW_BIT);
    if (l.irq_timer)    id = 5'(`IRQ_TIMER_BIT);
    if (l.irq_external) id = 5'(`IRQ_EXT_BIT);
    for (int k = 0; k < 16; k++) begin
      if (l.irq_fast[k]) id = 5'(`IRQ_FAST_LSB + k);
    end
    return id;
  endfunction

  ////////////////////
  // Word to lines
  ////////////////////

  always_comb begin
    lines_map.irq_software = word_i.pop_word[`IRQ_SW_BIT];
    lines_map.irq_timer    = word_i.pop_word[`IRQ_TIMER_BIT];
    lines_map.irq_external = word_i.pop_word[`IRQ_EXT_BIT];
    lines_map.irq_fast     = word_i.pop_word[`IRQ_FAST_LSB +: 16];
  end

  assign id_cur = line_id(lines_q);

  // Take the head only from IDLE and never during a flush
  assign word_i.pop = (state_q == IDLE) && !word_i.empty && !word_i.flush;

  ////////////////////
  // Handshake FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      lines_q <= '0;
      id_q    <= '0;
      we_q    <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (word_i.pop) begin
            lines_q <= lines_map;
            state_q <= ASSERT;
          end
        end
        ASSERT: begin
          if (word_i.flush) begin
            // Aborted request, no id reported
            lines_q <= '0;
            state_q <= IDLE;
          end else if (irq_ack_i) begin
            lines_q <= '0;
            id_q    <= id_cur;
            we_q    <= 1'b1;
            state_q <= ACK;
          end
        end
        ACK: begin
          we_q    <= 1'b0;
          state_q <= IDLE;
        end
        default: begin
          lines_q <= '0;
          we_q    <= 1'b0;
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign irq_lines_o  = lines_q;
  assign irq_act_id_o = id_q;
  assign irq_id_we_o  = we_q;

endmodule

// ==== hdl/irq_word_fifo.sv ====
`timescale 1ns/1ps
`include "irq_gen_params.svh"

module irq_word_fifo import irq_gen_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  irq_word_if.buffer    buf_io,
  output logic          overflow_o
);

  localparam int unsigned DEPTH = `IRQ_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  irq_word_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;
  logic             overflow_q;

  // Wrap at DEPTH, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  // Flush wins over both sides
  assign do_push = buf_io.push && !full && !buf_io.flush;
  assign do_pop  = buf_io.pop && (count_q != '0) && !buf_io.flush;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (buf_io.flush) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
        if (do_pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
        case ({do_push, do_pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
      // Word lost on a full buffer, flag held until reset
      if (buf_io.push && full && !buf_io.flush) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= buf_io.push_word;
    end
  end

  assign buf_io.empty    = (count_q == '0);
  assign buf_io.pop_word = mem_q[rd_ptr_q];
  assign overflow_o      = overflow_q;

endmodule

// ==== hdl/irq_word_if.sv ====
`timescale 1ns/1ps

interface irq_word_if import irq_gen_pkg::*; ();

  // Write side, producer to FIFO
  logic      push;
  irq_word_t push_word;
  // Discard every pending word
  logic      flush;

  // Read side, FIFO to consumer
  logic      empty;
  irq_word_t pop_word;
  logic      pop;

  modport producer (
    output push, push_word, flush
  );

  modport buffer (
    input  push, push_word, flush, pop,
    output empty, pop_word
  );

  // Consumer also sees flush to drop the word it holds
  modport consumer (
    input  empty, pop_word, flush,
    output pop
  );

endinterface

// ==== hdl/irq_word_source.sv ====
`timescale 1ns/1ps
`include "irq_gen_params.svh"

module irq_word_source import irq_gen_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  irq_mode_e    irq_mode_i,
  input  logic [15:0]  min_cycles_i,
  input  logic [15:0]  max_cycles_i,
  input  logic [4:0]   min_id_i,
  input  logic [4:0]   max_id_i,
  input  logic [31:0]  pc_i,
  input  logic [31:0]  pc_trig_i,
  input  irq_word_t    sw_lines_i,
  input  logic         sw_valid_i,
  irq_word_if.producer word_o
);

  // Word bits that reach a physical line
  localparam irq_word_t MAP_MASK = (32'h1 << `IRQ_SW_BIT) | (32'h1 << `IRQ_TIMER_BIT) |
                                   (32'h1 << `IRQ_EXT_BIT) | (32'hFFFF << `IRQ_FAST_LSB);

  irq_mode_e   mode_q;
  logic        flush_q;
  logic        push_q;
  irq_word_t   push_word_q;
  logic        push_d;
  irq_word_t   word_d;

  // Random engine
  irq_word_t   lfsr_q;
  irq_word_t   lfsr_s1;
  irq_word_t   lfsr_s2;
  logic [15:0] delay_raw;
  logic [15:0] delay_clamped;
  irq_word_t   id_mask;
  irq_word_t   rnd_word;
  logic        rnd_hit;
  logic        rnd_draw;
  logic        rnd_fire;
  logic        rnd_wait_q;
  logic [15:0] rnd_cnt_q;
  irq_word_t   rnd_word_q;

  // PC trigger
  logic        pc_match;
  logic        pc_match_q;

  // One Galois step, shift right and fold in taps on a set LSB
  function automatic irq_word_t lfsr_step(irq_word_t s);
    irq_word_t n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ `IRQ_LFSR_TAPS;
    end
    return n;
  endfunction

  ////////////////////
  // Random candidate
  ////////////////////

  // Each candidate consumes two steps, first for the delay, second for the word
  always_comb begin
    lfsr_s1 = lfsr_step(lfsr_q);
    lfsr_s2 = lfsr_step(lfsr_s1);
  end

  assign delay_raw = lfsr_s1[31:16];

  // Clamp into [min, max], min checked first
  always_comb begin
    if (delay_raw < min_cycles_i) begin
      delay_clamped = min_cycles_i;
    end else if (delay_raw > max_cycles_i) begin
      delay_clamped = max_cycles_i;
    end else begin
      delay_clamped = delay_raw;
    end
  end

  // Keep only ids inside [min_id, max_id]
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      id_mask[i] = (i >= int'(min_id_i)) && (i <= int'(max_id_i));
    end
  end

  assign rnd_word = lfsr_s2 & id_mask;
  // Candidate without any mapped line is skipped
  assign rnd_hit  = |(rnd_word & MAP_MASK);
  assign rnd_draw = (mode_q == RANDOM) && !rnd_wait_q;
  assign rnd_fire = (mode_q == RANDOM) && rnd_wait_q && (rnd_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q     <= `IRQ_LFSR_SEED;
      rnd_wait_q <= 1'b0;
      rnd_cnt_q  <= '0;
    end else if (mode_q != RANDOM) begin
      // Pending delay abandoned, LFSR keeps its position
      rnd_wait_q <= 1'b0;
    end else if (rnd_draw) begin
      lfsr_q <= lfsr_s2;
      if (rnd_hit) begin
        rnd_wait_q <= 1'b1;
        rnd_cnt_q  <= delay_clamped;
      end
    end else if (rnd_fire) begin
      rnd_wait_q <= 1'b0;
    end else begin
      rnd_cnt_q <= rnd_cnt_q - 16'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rnd_draw && rnd_hit) begin
      rnd_word_q <= rnd_word;
    end
  end

  ////////////////////
  // Word select
  ////////////////////

  assign pc_match = (pc_i == pc_trig_i);

  always_comb begin
    push_d = 1'b0;
    word_d = sw_lines_i;
    case (mode_q)
      RANDOM: begin
        push_d = rnd_fire;
        word_d = rnd_word_q;
      end
      PC_TRIG: begin
        // Rising edge of the match only, software line forced
        push_d = pc_match && !pc_match_q;
        word_d = sw_lines_i | (32'h1 << `IRQ_SW_BIT);
      end
      SOFTWARE_DEFINED: begin
        push_d = sw_valid_i && |(sw_lines_i & MAP_MASK);
      end
      default: begin
        push_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= STANDARD;
      flush_q    <= 1'b0;
      push_q     <= 1'b0;
      pc_match_q <= 1'b0;
    end else begin
      mode_q     <= irq_mode_i;
      // High in the first cycle mode_q reads STANDARD
      flush_q    <= (irq_mode_i == STANDARD) && (mode_q != STANDARD);
      push_q     <= push_d;
      pc_match_q <= pc_match;
    end
  end

  always_ff @(posedge clk_i) begin
    push_word_q <= word_d;
  end

  assign word_o.push      = push_q;
  assign word_o.push_word = push_word_q;
  assign word_o.flush     = flush_q;

endmodule

// ==== verification/irq_gen_checker.sv ====
`timescale 1ns/1ps

module irq_gen_checker import irq_gen_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       irq_ack_i,
  input irq_lines_t irq_lines_o,
  input logic       irq_id_we_o,
  input drv_state_e state_i
);

  ////////////////////
  // Handshake
  ////////////////////

  // Write enable is a single-cycle pulse
  we_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(irq_id_we_o) |=> !irq_id_we_o)
    else $error("id write enable held longer than one cycle");

  // Write enable only in the cycle after an acknowledge
  we_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_id_we_o |-> $past(irq_ack_i))
    else $error("id write enable without a preceding acknowledge");

  // Lines frozen while the request is held
  lines_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == ASSERT) && ($past(state_i) == ASSERT) |-> $stable(irq_lines_o))
    else $error("lines changed while held");

  // Reset clears every line
  lines_reset: assert property (@(posedge clk_i)
    !rst_ni |=> (irq_lines_o == '0) && !irq_id_we_o)
    else $error("lines not cleared by reset");

endmodule

// The FSM state lives in the line driver
bind irq_line_driver irq_gen_checker i_checker (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .irq_ack_i   (irq_ack_i),
  .irq_lines_o (irq_lines_o),
  .irq_id_we_o (irq_id_we_o),
  .state_i     (state_q)
);

// ==== verification/irq_gen_tb.sv ====
`timescale 1ns/1ps
`include "irq_gen_params.svh"

module irq_gen_tb import irq_gen_pkg::*; ();

  localparam int SW_WORDS  = 8;
  localparam int RND_WORDS = 5;
  localparam int MIN_DLY   = 20;
  localparam int MAX_DLY   = 40;
  // Slack between LFSR delay and ack-to-lines gap
  localparam int PIPE      = 6;
  localparam int OVF_WORDS = `IRQ_FIFO_DEPTH + 2;
  localparam int LIMIT     = (SW_WORDS + 1 + RND_WORDS + 2 + OVF_WORDS) * (MAX_DLY + 40);
  localparam logic [31:0] MAP = (32'h1 << `IRQ_SW_BIT) | (32'h1 << `IRQ_TIMER_BIT) |
                                (32'h1 << `IRQ_EXT_BIT) | (32'hFFFF << `IRQ_FAST_LSB);

  logic clk_i, rst_ni, sw_valid_i, irq_ack_i;
  logic [1:0] irq_mode_i;
  logic [15:0] irq_min_cycles_i, irq_max_cycles_i;
  logic [4:0] irq_min_id_i, irq_max_id_i, irq_act_id_o;
  logic [31:0] irq_pc_i, irq_pc_trig_i, sw_lines_i;
  irq_lines_t irq_lines_o, held_lines, prev_lines, exp_l;
  irq_lines_t flush_exp;
  logic [4:0] flush_id;
  logic irq_id_we_o, irq_overflow_o;

  integer seed = 86;
  int checks, err_value, err_other, delivered, cyc, last_we, gap, d, tgt;
  logic ack_en, rnd_phase, rnd_first;
  logic [31:0] w, lfsr_model;
  logic [4:0] exp_id;
  logic [31:0] exp_q[$];
  int delay_q[$];

  irq_gen_top i_irq_gen_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Word bits to lines, id is the highest set line number
  function automatic void ref_lines(input logic [31:0] wd, output irq_lines_t l,
                                    output logic [4:0] id);
    l = {wd[`IRQ_SW_BIT], wd[`IRQ_TIMER_BIT], wd[`IRQ_EXT_BIT], wd[`IRQ_FAST_LSB +: 16]};
    id = 5'd0;
    if (wd[`IRQ_SW_BIT]) id = 5'(`IRQ_SW_BIT);
    if (wd[`IRQ_TIMER_BIT]) id = 5'(`IRQ_TIMER_BIT);
    if (wd[`IRQ_EXT_BIT]) id = 5'(`IRQ_EXT_BIT);
    for (int k = 0; k < 16; k++) begin
      if (wd[`IRQ_FAST_LSB + k]) id = 5'(`IRQ_FAST_LSB + k);
    end
  endfunction

  // Galois step, taps folded in when the LSB falls out
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ `IRQ_LFSR_TAPS) : (s >> 1);
  endfunction

  // Queue the next n random words and their delays, skipped draws cost a cycle each
  task automatic gen_random_expect(input int n);
    logic [31:0] s1, s2, cand;
    int skips, dl;
    skips = 0;
    while (n > 0) begin
      s1 = lfsr_next(lfsr_model);
      s2 = lfsr_next(s1);
      lfsr_model = s2;
      dl = (s1[31:16] < MIN_DLY) ? MIN_DLY : (s1[31:16] > MAX_DLY) ? MAX_DLY : s1[31:16];
      cand = '0;
      for (int i = 0; i < 32; i++) begin
        if (i >= irq_min_id_i && i <= irq_max_id_i) cand[i] = s2[i];
      end
      if ((cand & MAP) == '0) begin
        skips++;
      end else begin
        exp_q.push_back(cand);
        delay_q.push_back(dl + skips);
        skips = 0;
        n--;
      end
    end
  endtask

  ////////////////////
  // Compare
  ////////////////////

  task automatic check_lines(input irq_lines_t got, input irq_lines_t exp, input string what);
    checks++;
    if (got !== exp) begin
      err_value++;
      $display("ERR %0t: %s lines %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_id(input logic [4:0] got, input logic [4:0] exp);
    checks++;
    if (got !== exp) begin
      err_value++;
      $display("ERR %0t: id %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      err_value++;
      $display("ERR %0t: overflow %b, expected %b", $time, got, exp);
    end
  endtask

  // Outputs settle after the rising edge, sampled on the falling one
  always @(negedge clk_i) begin
    if (rst_ni) begin
      cyc++;
      if (irq_lines_o != '0 && prev_lines == '0 && rnd_phase && delay_q.size() > 0) begin
        d = delay_q.pop_front();
        gap = cyc - last_we;
        if (!rnd_first && (gap + PIPE < d || gap > d + PIPE)) begin
          err_value++;
          $display("ERR %0t: random gap %0d, delay %0d", $time, gap, d);
        end
        rnd_first = 1'b0;
      end
      if (irq_lines_o != '0) held_lines = irq_lines_o;
      if (irq_id_we_o) begin
        last_we = cyc;
        delivered++;
        if (exp_q.size() == 0) begin
          err_other++;
          $display("Unexpected interrupt delivered at %0t", $time);
        end else begin
          ref_lines(exp_q.pop_front(), exp_l, exp_id);
          check_lines(held_lines, exp_l, "delivered");
          check_id(irq_act_id_o, exp_id);
        end
      end
      prev_lines = irq_lines_o;
    end
  end

  // Core model, acknowledges after a random 0 to 3 cycles
  always begin
    @(negedge clk_i);
    if (ack_en && irq_lines_o != '0) begin
      repeat ($unsigned($random(seed)) % 4) @(negedge clk_i);
      irq_ack_i = 1'b1;
      @(negedge clk_i);
      irq_ack_i = 1'b0;
      @(negedge clk_i);
    end
  end

  initial begin
    #(LIMIT * 20);
    $display("Watchdog expired, the run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic set_mode(input irq_mode_e m, input int settle);
    @(negedge clk_i);
    irq_mode_i = m;
    repeat (settle) @(negedge clk_i);
  endtask

  task automatic send_sw(input logic [31:0] wd);
    @(negedge clk_i);
    sw_lines_i = wd;
    sw_valid_i = 1'b1;
    if ((wd & MAP) != '0) exp_q.push_back(wd);
    @(negedge clk_i);
    sw_valid_i = 1'b0;
  endtask

  task automatic wait_delivered(input int target, input int limit);
    int n;
    n = 0;
    while (delivered < target && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (delivered < target) begin
      err_other++;
      $display("Timed out waiting for interrupt %0d", target);
    end
  endtask

  initial begin
    {rst_ni, sw_valid_i, irq_ack_i, irq_mode_i} = '0;
    {irq_pc_i, sw_lines_i} = '0;
    irq_pc_trig_i = 32'h8000_0100;
    irq_min_cycles_i = 16'(MIN_DLY);
    irq_max_cycles_i = 16'(MAX_DLY);
    irq_min_id_i = 5'd3;
    irq_max_id_i = 5'd20;
    {checks, err_value, err_other, delivered, cyc, last_we} = '0;
    {ack_en, rnd_phase, rnd_first} = '0;
    lfsr_model = `IRQ_LFSR_SEED;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Software words, every third one without a mapped bit
    ack_en = 1'b1;
    set_mode(SOFTWARE_DEFINED, 2);
    for (int i = 0; i < SW_WORDS; i++) begin
      w = $random(seed);
      if (i % 3 == 2) w = w & ~MAP;
      if ((w & MAP) == '0) w[0] = 1'b1;
      tgt = delivered + (((w & MAP) != '0) ? 1 : 0);
      send_sw(w);
      wait_delivered(tgt, 40);
      repeat (5) @(negedge clk_i);
    end

    // PC match held for many cycles raises a single word
    set_mode(STANDARD, 3);
    sw_lines_i = 32'h0001_0080;
    set_mode(PC_TRIG, 3);
    tgt = delivered + 1;
    exp_q.push_back(sw_lines_i | (32'h1 << `IRQ_SW_BIT));
    irq_pc_i = irq_pc_trig_i;
    repeat (15) @(negedge clk_i);
    irq_pc_i = irq_pc_trig_i + 32'd4;
    wait_delivered(tgt, 40);
    repeat (20) @(negedge clk_i);

    // Random words against the LFSR model
    set_mode(STANDARD, 3);
    gen_random_expect(RND_WORDS);
    rnd_phase = 1'b1;
    rnd_first = 1'b1;
    tgt = delivered + RND_WORDS;
    set_mode(RANDOM, 0);
    wait_delivered(tgt, RND_WORDS * (MAX_DLY + 20));
    ack_en = 1'b0;
    rnd_phase = 1'b0;
    set_mode(STANDARD, 3);
    exp_q.delete();
    delay_q.delete();

    // Standard mode drops a held request and a pending word
    set_mode(SOFTWARE_DEFINED, 2);
    send_sw(32'h0000_0808);
    send_sw(32'h0004_0000);
    repeat (6) @(negedge clk_i);
    // First word is on the lines before standard mode is entered
    ref_lines(32'h0000_0808, flush_exp, flush_id);
    check_lines(irq_lines_o, flush_exp, "held before flush");
    tgt = delivered;
    set_mode(STANDARD, 4);
    check_lines(irq_lines_o, '0, "after flush");
    exp_q.delete();
    ack_en = 1'b1;
    set_mode(SOFTWARE_DEFINED, 20);
    check_lines(irq_lines_o, '0, "discarded");
    if (delivered != tgt) begin
      err_other++;
      $display("Flushed request was reported");
    end

    // Back-to-back words overrun the FIFO while the driver holds one
    ack_en = 1'b0;
    check_flag(irq_overflow_o, 1'b0);
    tgt = delivered + OVF_WORDS - 1;
    for (int i = 0; i < OVF_WORDS; i++) begin
      @(negedge clk_i);
      sw_lines_i = $random(seed) | 32'h80;
      sw_valid_i = 1'b1;
      if (i < OVF_WORDS - 1) exp_q.push_back(sw_lines_i);
    end
    @(negedge clk_i);
    sw_valid_i = 1'b0;
    repeat (3) @(negedge clk_i);
    check_flag(irq_overflow_o, 1'b1);
    ack_en = 1'b1;
    wait_delivered(tgt, OVF_WORDS * 20);
    repeat (10) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      err_other++;
      $display("%0d expected interrupts never arrived", exp_q.size());
    end

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/irq_gen_pkg.sv
hdl/irq_word_if.sv
hdl/irq_word_source.sv
hdl/irq_word_fifo.sv
hdl/irq_line_driver.sv
hdl/irq_gen_top.sv
verification/irq_gen_checker.sv
verification/irq_gen_tb.sv
